/* logic/address_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module address_unit import mesm_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  insn_t                insn,
    input  logic                 latch,         // take address field
    input  logic                 write_m,       // vtm / utm
    input  logic                 write_c,       // utc
    input  logic                 clear_c,       // C used up
    output logic [ADDR_BITS-1:0] eff_addr,      // vaddr + M[i]
    output logic [ADDR_BITS-1:0] vaddr          // addr + C, latched
);

    logic [ADDR_BITS-1:0] m_reg [1:NUM_INDEX-1];    // M1..M15
    logic [ADDR_BITS-1:0] c_reg;
    logic                 c_active;             // last insn was utc
    logic [3:0]           index;                // latched ir field
    logic [ADDR_BITS-1:0] m_sel;

    // ----------------------------------------
    // C modifier
    always_ff @(posedge clk) begin
        if (reset) begin
            c_reg    <= '0;
            c_active <= 1'b0;
        end else if (write_c) begin
            c_reg    <= eff_addr;
            c_active <= 1'b1;
        end else if (clear_c)
            c_active <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            vaddr <= c_active ? insn.addr + c_reg : insn.addr;
            index <= insn.ir;
        end
    end

    // ----------------------------------------
    // index registers
    assign m_sel    = (index == 4'd0) ? '0 : m_reg[index];  // M0 is zero
    assign eff_addr = vaddr + m_sel;

    always_ff @(posedge clk) begin
        if (write_m && index != 4'd0)
            m_reg[index] <= (insn.op == OP_VTM) ? vaddr : eff_addr;
    end

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter import mesm_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t fetch_req,
    input  mem_req_t data_req,
    output mem_rsp_t fetch_rsp,
    output mem_rsp_t data_rsp,
    output axi_m2s_t axi,
    input  axi_s2m_t axi_in
);

    typedef enum logic [1:0] {
        ARB_IDLE, ARB_ADDR, ARB_RESP
    } arb_state_e;

    arb_state_e           state;
    logic                 grant_data;       // owner, data over fetch
    logic                 aw_done, w_done;  // write channels finished
    logic                 aw_hs, w_hs;
    logic                 done_q;
    logic [WORD_BITS-1:0] rdata_q;
    mem_req_t             cur;              // granted request

    assign cur   = grant_data ? data_req : fetch_req;  // fields held by owner
    assign aw_hs = axi.awvalid && axi_in.awready;
    assign w_hs  = axi.wvalid && axi_in.wready;

    // ----------------------------------------
    // AXI side, decoded from state
    assign axi.awvalid = (state == ARB_ADDR) && cur.write && !aw_done;
    assign axi.awaddr  = cur.addr;
    assign axi.wvalid  = (state == ARB_ADDR) && cur.write && !w_done;
    assign axi.wdata   = cur.wdata;
    assign axi.bready  = (state == ARB_RESP) && cur.write;
    assign axi.arvalid = (state == ARB_ADDR) && !cur.write;
    assign axi.araddr  = cur.addr;
    assign axi.rready  = (state == ARB_RESP) && !cur.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ARB_IDLE;
            grant_data <= 1'b0;
            aw_done    <= 1'b0;
            w_done     <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    // owner still holds valid during its done cycle
                    if (!done_q && (data_req.valid || fetch_req.valid)) begin
                        grant_data <= data_req.valid;
                        aw_done    <= 1'b0;
                        w_done     <= 1'b0;
                        state      <= ARB_ADDR;
                    end
                end
                ARB_ADDR: begin
                    if (cur.write) begin
                        aw_done <= aw_done || aw_hs;
                        w_done  <= w_done || w_hs;
                        if ((aw_done || aw_hs) && (w_done || w_hs))
                            state <= ARB_RESP;
                    end else if (axi.arvalid && axi_in.arready)
                        state <= ARB_RESP;
                end
                ARB_RESP: begin
                    if ((axi.bready && axi_in.bvalid) || (axi.rready && axi_in.rvalid)) begin
                        done_q <= 1'b1;     // done one cycle after B or R
                        state  <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (axi.rready && axi_in.rvalid)
            rdata_q <= axi_in.rdata;
    end

    // ----------------------------------------
    // responses to the owner
    assign fetch_rsp = '{done: done_q && !grant_data, rdata: rdata_q};
    assign data_rsp  = '{done: done_q && grant_data, rdata: rdata_q};

endmodule

`default_nettype wire

/* logic/exec_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_sequencer import mesm_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  insn_t insn,
    input  logic  cached,
    input  logic  acc_zero,
    input  logic  operand_busy,
    output logic  need_word,
    output logic  advance,
    output logic  load_pc_en,
    output logic  latch,
    output logic  write_m,
    output logic  write_c,
    output logic  clear_c,
    output logic  load,
    output logic  store,
    output logic  halted
);

    exec_state_e state, next_state;
    logic        take;                      // jump taken

    assign take = (insn.op == OP_UJ) ||
                  (insn.op == OP_UZA && acc_zero) ||
                  (insn.op == OP_U1A && !acc_zero);

    always_ff @(posedge clk) begin
        if (reset)
            state <= ST_FETCH;
        else
            state <= next_state;
    end

    assign halted = (state == ST_HALT);

    // ----------------------------------------
    // next state and unit controls
    always_comb begin
        need_word  = 1'b0;
        advance    = 1'b0;
        load_pc_en = 1'b0;
        latch      = 1'b0;
        write_m    = 1'b0;
        write_c    = 1'b0;
        clear_c    = 1'b0;
        load       = 1'b0;
        store      = 1'b0;
        next_state = state;
        case (state)
            ST_FETCH: begin
                if (cached) begin
                    latch      = 1'b1;      // vaddr and index taken here
                    next_state = ST_DECODE;
                end else
                    need_word = 1'b1;       // wait for the word
            end
            ST_DECODE: begin
                if (insn.op == OP_UTC)
                    write_c = 1'b1;         // C for the next insn only
                else
                    clear_c = 1'b1;
                case (insn.op)
                    OP_XTA, OP_ATX: next_state = ST_MEM;
                    OP_STOP:        next_state = ST_HALT;
                    OP_VTM, OP_UTM: begin
                        write_m    = 1'b1;
                        advance    = 1'b1;
                        next_state = ST_FETCH;
                    end
                    default: begin          // utc, jumps, no-ops
                        load_pc_en = take;
                        advance    = !take;
                        next_state = ST_FETCH;
                    end
                endcase
            end
            ST_MEM: begin
                load       = (insn.op == OP_XTA);   // eff_addr settled by now
                store      = (insn.op == OP_ATX);
                next_state = ST_WAIT;
            end
            ST_WAIT: begin
                if (!operand_busy) begin    // A written on done
                    advance    = 1'b1;
                    next_state = ST_FETCH;
                end
            end
            ST_HALT: next_state = ST_HALT;  // until reset
            default: next_state = ST_FETCH;
        endcase
    end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import mesm_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 need_word,     // word at pc missing
    input  logic                 advance,       // step one half
    input  logic                 load_pc_en,    // jump
    input  logic [ADDR_BITS-1:0] load_pc,       // jump target, word address
    output insn_t                insn,          // current half, decoded
    output logic                 cached,        // word at pc present
    output mem_req_t             fetch_req,
    input  mem_rsp_t             fetch_rsp
);

    logic [PC_BITS-1:0]   pc;                   // lsb selects the half
    logic [WORD_BITS-1:0] word;                 // opcode cache
    logic [ADDR_BITS-1:0] word_addr;            // address of cached word
    logic                 word_valid;
    logic                 req_valid;
    logic [ADDR_BITS-1:0] req_addr;
    logic [INSN_BITS-1:0] half;

    // ----------------------------------------
    // pc and request control
    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= '0;
            word_valid <= 1'b0;             // cache empty
            req_valid  <= 1'b0;
        end else begin
            if (load_pc_en)
                pc <= {load_pc, 1'b0};      // jumps land on the left half
            else if (advance)
                pc <= pc + 1'b1;
            if (fetch_rsp.done) begin
                req_valid  <= 1'b0;
                word_valid <= 1'b1;
            end else if (need_word && !req_valid)
                req_valid <= 1'b1;          // need_word may stay high, issue once
        end
    end

    always_ff @(posedge clk) begin
        if (need_word && !req_valid)
            req_addr <= pc[PC_BITS-1:1];
        if (fetch_rsp.done) begin
            word      <= fetch_rsp.rdata;
            word_addr <= req_addr;
        end
    end

    assign fetch_req = '{valid: req_valid, write: 1'b0, addr: req_addr, wdata: '0};
    assign cached    = word_valid && (word_addr == pc[PC_BITS-1:1]);

    // ----------------------------------------
    // half selection and decode
    always_comb begin
        half    = pc[0] ? word[INSN_BITS-1:0] : word[WORD_BITS-1:INSN_BITS];  // left first
        insn.ir = half[23:20];
        insn.op = OP_NOP;                   // anything unknown is a no-op
        if (half[19]) begin                 // long format
            insn.addr = half[14:0];
            case (half[18:15])
                LCMD_UTC:  insn.op = OP_UTC;
                LCMD_VTM:  insn.op = OP_VTM;
                LCMD_UTM:  insn.op = OP_UTM;
                LCMD_UZA:  insn.op = OP_UZA;
                LCMD_U1A:  insn.op = OP_U1A;
                LCMD_UJ:   insn.op = OP_UJ;
                LCMD_STOP: insn.op = OP_STOP;
                default:   insn.op = OP_NOP;
            endcase
        end else begin                      // short format, 12-bit address
            insn.addr = {{3{half[18]}}, half[11:0]};
            case (half[17:12])
                SCMD_ATX: insn.op = OP_ATX;
                SCMD_XTA: insn.op = OP_XTA;
                default:  insn.op = OP_NOP;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/mesm_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mesm_core import mesm_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    output axi_m2s_t axi,                   // AXI4-Lite master
    input  axi_s2m_t axi_in,
    output logic     halted                 // stop executed
);

    insn_t                insn;
    logic                 cached;
    logic                 need_word, advance, load_pc_en;
    logic                 latch, write_m, write_c, clear_c;
    logic                 load, store, operand_busy, acc_zero;
    logic [ADDR_BITS-1:0] eff_addr;         // addr + C + M[i]
    mem_req_t             fetch_req, data_req;
    mem_rsp_t             fetch_rsp, data_rsp;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .need_word  (need_word),
        .advance    (advance),
        .load_pc_en (load_pc_en),
        .load_pc    (eff_addr),             // jump target
        .insn       (insn),
        .cached     (cached),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp)
    );

    exec_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .insn         (insn),
        .cached       (cached),
        .acc_zero     (acc_zero),
        .operand_busy (operand_busy),
        .need_word    (need_word),
        .advance      (advance),
        .load_pc_en   (load_pc_en),
        .latch        (latch),
        .write_m      (write_m),
        .write_c      (write_c),
        .clear_c      (clear_c),
        .load         (load),
        .store        (store),
        .halted       (halted)
    );

    address_unit u_addr (
        .clk      (clk),
        .reset    (reset),
        .insn     (insn),
        .latch    (latch),
        .write_m  (write_m),
        .write_c  (write_c),
        .clear_c  (clear_c),
        .eff_addr (eff_addr),
        .vaddr    ()                        // consumed inside, by vtm
    );

    operand_unit u_opnd (
        .clk      (clk),
        .reset    (reset),
        .load     (load),
        .store    (store),
        .addr     (eff_addr),
        .busy     (operand_busy),
        .acc_zero (acc_zero),
        .data_req (data_req),
        .data_rsp (data_rsp)
    );

    bus_arbiter u_arb (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .axi       (axi),
        .axi_in    (axi_in)
    );

endmodule

`default_nettype wire

/* logic/mesm_pkg.sv */
`default_nettype none

package mesm_pkg;

    // ----------------------------------------
    // widths
    localparam int ADDR_BITS = 15;          // word address
    localparam int WORD_BITS = 48;          // memory word
    localparam int INSN_BITS = 24;          // one instruction, half a word
    localparam int PC_BITS   = 16;          // half-word program counter
    localparam int NUM_INDEX = 16;          // M0..M15, M0 reads zero

    // command field values
    localparam logic [5:0] SCMD_ATX  = 6'o00;   // short format
    localparam logic [5:0] SCMD_XTA  = 6'o10;
    localparam logic [3:0] LCMD_UTC  = 4'd2;    // long format
    localparam logic [3:0] LCMD_VTM  = 4'd4;
    localparam logic [3:0] LCMD_UTM  = 4'd5;
    localparam logic [3:0] LCMD_UZA  = 4'd6;
    localparam logic [3:0] LCMD_U1A  = 4'd7;
    localparam logic [3:0] LCMD_UJ   = 4'd8;
    localparam logic [3:0] LCMD_STOP = 4'd11;

    // ----------------------------------------
    // enums
    typedef enum logic [4:0] {
        OP_ATX, OP_XTA,                     // short format
        OP_UTC, OP_VTM, OP_UTM, OP_UJ,      // long format
        OP_UZA, OP_U1A, OP_STOP, OP_NOP
    } mesm_op_e;

    typedef enum logic [2:0] {
        ST_FETCH, ST_DECODE, ST_MEM, ST_WAIT, ST_HALT
    } exec_state_e;

    // ----------------------------------------
    // buses
    typedef struct packed {
        logic                 valid;        // held until done
        logic                 write;
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BITS-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 done;         // one-cycle pulse
        logic [WORD_BITS-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                 awvalid;
        logic [ADDR_BITS-1:0] awaddr;
        logic                 wvalid;
        logic [WORD_BITS-1:0] wdata;
        logic                 bready;
        logic                 arvalid;
        logic [ADDR_BITS-1:0] araddr;
        logic                 rready;
    } axi_m2s_t;

    typedef struct packed {
        logic                 awready;
        logic                 wready;
        logic                 bvalid;
        logic [1:0]           bresp;        // not checked
        logic                 arready;
        logic                 rvalid;
        logic [WORD_BITS-1:0] rdata;
        logic [1:0]           rresp;        // not checked
    } axi_s2m_t;

    typedef struct packed {
        mesm_op_e             op;
        logic [3:0]           ir;           // index register number
        logic [ADDR_BITS-1:0] addr;         // sign-extended for short format
    } insn_t;

endpackage

`default_nettype wire

/* logic/operand_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_unit import mesm_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,          // xta
    input  logic                 store,         // atx
    input  logic [ADDR_BITS-1:0] addr,
    output logic                 busy,
    output logic                 acc_zero,
    output mem_req_t             data_req,
    input  mem_rsp_t             data_rsp
);

    logic [WORD_BITS-1:0] acc;                  // A
    logic                 req_valid;
    logic                 req_write;
    logic [ADDR_BITS-1:0] req_addr;
    logic [WORD_BITS-1:0] req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            req_valid <= 1'b0;
        end else if (data_rsp.done) begin
            req_valid <= 1'b0;
            if (!req_write)
                acc <= data_rsp.rdata;      // load completes
        end else if ((load || store) && !req_valid)
            req_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if ((load || store) && !req_valid) begin
            req_write <= store;
            req_addr  <= addr;
            req_wdata <= acc;               // only A goes to memory
        end
    end

    assign data_req = '{valid: req_valid, write: req_write, addr: req_addr, wdata: req_wdata};
    assign busy     = req_valid || load || store;
    assign acc_zero = (acc == '0);          // logical group test

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mesm_core -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mesm_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

/* tb/axi_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module axi_mem_model import mesm_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  axi_m2s_t             m2s,
    output axi_s2m_t             s2m,
    input  logic                 prog_we,       // preload, one word per cycle
    input  logic [ADDR_BITS-1:0] prog_addr,
    input  logic [WORD_BITS-1:0] prog_data
);

    logic [WORD_BITS-1:0] mem [0:63];           // 64 words
    integer               seed = 32'h21d7;
    logic [1:0]           aw_wait, w_wait, ar_wait, r_wait;   // ready delays, 0..3
    logic                 aw_got, w_got, ar_got;
    logic [ADDR_BITS-1:0] aw_addr, ar_addr;
    logic [WORD_BITS-1:0] w_data, rdata;
    logic                 awready, wready, bvalid, arready, rvalid;

    assign s2m = '{awready: awready, wready: wready, bvalid: bvalid, bresp: 2'b00,
                   arready: arready, rvalid: rvalid, rdata: rdata, rresp: 2'b00};

    always @(posedge clk) begin
        if (prog_we)
            mem[prog_addr[5:0]] <= prog_data;
        if (reset) begin
            {awready, wready, bvalid, arready, rvalid} <= '0;
            {aw_got, w_got, ar_got}                    <= '0;
            {aw_wait, w_wait, ar_wait, r_wait}         <= '0;
        end else begin
            // ----------------------------------------
            // write address and data, each with its own delay
            if (m2s.awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                aw_addr <= m2s.awaddr;
                aw_wait <= 2'($random(seed));   // for the next write
            end else if (m2s.awvalid && !aw_got) begin
                if (aw_wait == 2'd0) awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            if (m2s.wvalid && wready) begin
                wready <= 1'b0;
                w_got  <= 1'b1;
                w_data <= m2s.wdata;
                w_wait <= 2'($random(seed));
            end else if (m2s.wvalid && !w_got) begin
                if (w_wait == 2'd0) wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            if (bvalid && m2s.bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (aw_got && w_got && !bvalid) begin
                bvalid <= 1'b1;
                if (aw_addr[ADDR_BITS-1:6] == '0)
                    mem[aw_addr[5:0]] <= w_data;    // beyond 64 words, dropped
            end
            // ----------------------------------------
            // read address, then data after a delay
            if (m2s.arvalid && arready) begin
                arready <= 1'b0;
                ar_got  <= 1'b1;
                ar_addr <= m2s.araddr;
                r_wait  <= 2'($random(seed));
            end else if (m2s.arvalid && !ar_got) begin
                if (ar_wait == 2'd0) arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            if (rvalid && m2s.rready) begin
                rvalid  <= 1'b0;
                ar_got  <= 1'b0;
                ar_wait <= 2'($random(seed));
            end else if (ar_got && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[ar_addr[5:0]];
                end else
                    r_wait <= r_wait - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mesm_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mesm_core import mesm_pkg::*; ();

    localparam int NUM_TESTS   = 7;
    localparam int TEST_CYCLES = 400;           // longest program needs well under 100

    typedef struct packed {
        logic [7:0][WORD_BITS-1:0] prog;        // words 0..7
        logic [WORD_BITS-1:0]      data;        // word at address 40
        logic [WORD_BITS-1:0]      wdata;       // expected store data
        logic [7:0]                writes;      // expected AW handshakes
        logic [ADDR_BITS-1:0]      addr1;       // first write
        logic [ADDR_BITS-1:0]      addr2;       // second write, if any
        logic [7:0]                reads;       // expected AR handshakes
    } test_t;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 halted;
    axi_m2s_t             axi;
    axi_s2m_t             axi_in;
    logic                 prog_we;
    logic [ADDR_BITS-1:0] prog_addr;
    logic [WORD_BITS-1:0] prog_data;
    test_t                tests [NUM_TESTS];
    string                names [NUM_TESTS];
    int                   table_len, passed, failed, test_errs;
    logic                 timed_out;
    logic [7:0]           aw_count, w_count, ar_count;
    logic [ADDR_BITS-1:0] wr_addr [4];          // captured at the port
    logic [WORD_BITS-1:0] wr_data [4];

    always #4 clk = ~clk;

    mesm_core UUT (.clk(clk), .reset(reset), .axi(axi), .axi_in(axi_in), .halted(halted));

    axi_mem_model mem_model (.clk(clk), .reset(reset), .m2s(axi), .s2m(axi_in),
                             .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data));

    // ----------------------------------------
    // port monitor
    always @(posedge clk) begin
        if (reset) begin
            aw_count <= '0;
            w_count  <= '0;
            ar_count <= '0;
        end else begin
            if (axi.awvalid && axi_in.awready) begin
                if (aw_count < 8'd4) wr_addr[aw_count[1:0]] <= axi.awaddr;
                aw_count <= aw_count + 8'd1;
            end
            if (axi.wvalid && axi_in.wready) begin
                if (w_count < 8'd4) wr_data[w_count[1:0]] <= axi.wdata;
                w_count <= w_count + 8'd1;
            end
            if (axi.arvalid && axi_in.arready)
                ar_count <= ar_count + 8'd1;    // fetches and loads alike
        end
    end

    // instruction encoders
    function automatic logic [INSN_BITS-1:0] short_fmt(input logic [3:0] ir,
            input logic [5:0] cmd, input logic [11:0] addr);
        short_fmt = {ir, 1'b0, 1'b0, cmd, addr};    // bit 18 clear, positive address
    endfunction

    function automatic logic [INSN_BITS-1:0] long_fmt(input logic [3:0] ir,
            input logic [3:0] cmd, input logic [14:0] addr);
        long_fmt = {ir, 1'b1, cmd, addr};
    endfunction

    function automatic logic [WORD_BITS-1:0] stop_word();
        stop_word = {long_fmt(0, LCMD_STOP, 0), long_fmt(0, 4'd0, 0)};  // long 0 is unused
    endfunction

    function automatic logic [WORD_BITS-1:0] memory_word(input logic [2:0] i,
            input logic [5:0] a);
        if (a < 6'd8)
            memory_word = tests[i].prog[a[2:0]];
        else if (a == 6'd40)
            memory_word = tests[i].data;
        else
            memory_word = {a, 6'h2a, ~a, 6'h15, a, 12'hc35, a};
    endfunction

    task automatic add_test(input string name,
            input logic [WORD_BITS-1:0] w0, w1, w2, w3, data, wdata,
            input logic [7:0] writes, input logic [ADDR_BITS-1:0] addr1, addr2,
            input logic [7:0] reads);
        tests[table_len].prog   = {{4{stop_word()}}, w3, w2, w1, w0};
        tests[table_len].data   = data;
        tests[table_len].wdata  = wdata;
        tests[table_len].writes = writes;
        tests[table_len].addr1  = addr1;
        tests[table_len].addr2  = addr2;
        tests[table_len].reads  = reads;
        names[table_len]        = name;
        table_len++;
    endtask

    task automatic compare(input logic [2:0] i, input string what,
            input logic [WORD_BITS-1:0] expected, input logic [WORD_BITS-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: %s expected %0h, actual %0h", names[i], what, expected, actual);
            test_errs++;
        end
    endtask

    // ----------------------------------------
    // one test: load memory, reset, run to stop, check the port
    task automatic run_test(input logic [2:0] i);
        int         cycles;
        logic [6:0] a;
        test_errs = 0;
        for (a = 7'd0; a < 7'd64; a = a + 7'd1) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= {9'd0, a[5:0]};
            prog_data <= memory_word(i, a[5:0]);
        end
        @(posedge clk);
        prog_we <= 1'b0;
        reset   <= 1'b1;
        repeat (5) @(posedge clk);
        reset  <= 1'b0;
        cycles = 0;
        while (!halted && cycles < TEST_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("test %s: halted did not rise within %0d cycles, run aborted",
                     names[i], TEST_CYCLES);
            timed_out = 1'b1;
            failed++;
        end else begin
            repeat (4) @(negedge clk);          // nothing may move after stop
            if (!halted) begin
                $display("test %s: halted dropped after stop", names[i]);
                test_errs++;
            end
            compare(i, "write count", 48'(tests[i].writes), 48'(aw_count));
            compare(i, "data beats", 48'(tests[i].writes), 48'(w_count));
            compare(i, "read count", 48'(tests[i].reads), 48'(ar_count));
            if (tests[i].writes >= 8'd1) begin
                compare(i, "first write addr", 48'(tests[i].addr1), 48'(wr_addr[0]));
                compare(i, "first write data", tests[i].wdata, wr_data[0]);
            end
            if (tests[i].writes >= 8'd2) begin
                compare(i, "second write addr", 48'(tests[i].addr2), 48'(wr_addr[1]));
                compare(i, "second write data", tests[i].wdata, wr_data[1]);
            end
            if (test_errs == 0) passed++;
            else failed++;
            $display("test %-12s %s after %0d cycles", names[i],
                     (test_errs == 0) ? "passed" : "FAILED", cycles);
        end
    endtask

    initial begin
        reset     <= 1'b1;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        table_len = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;

        // name, words 0..3, data at 40, store data, writes, addr1, addr2, reads
        add_test("load_store",
                 {short_fmt(0, SCMD_XTA, 40), short_fmt(0, SCMD_ATX, 41)},
                 stop_word(), stop_word(), stop_word(),
                 48'h1234_5678_9abc, 48'h1234_5678_9abc, 1, 41, 0, 3);
        add_test("index_addr",
                 {long_fmt(2, LCMD_VTM, 3), short_fmt(2, SCMD_XTA, 37)},
                 {short_fmt(2, SCMD_ATX, 50), long_fmt(0, LCMD_STOP, 0)},
                 stop_word(), stop_word(),
                 48'h0f0f_a5a5_3c3c, 48'h0f0f_a5a5_3c3c, 1, 53, 0, 3);
        add_test("c_modifier",
                 {long_fmt(0, LCMD_UTC, 5), short_fmt(0, SCMD_XTA, 35)},
                 {long_fmt(0, LCMD_UTC, 5), short_fmt(0, SCMD_ATX, 60)},
                 {short_fmt(0, SCMD_ATX, 60), long_fmt(0, LCMD_STOP, 0)}, stop_word(),
                 48'h8000_0000_0001, 48'h8000_0000_0001, 2, 65, 60, 4);
        add_test("uza_taken",                   // A nonzero first, then zero loaded
                 {short_fmt(0, SCMD_XTA, 41), short_fmt(0, SCMD_XTA, 40)},
                 {long_fmt(0, LCMD_UZA, 3), short_fmt(0, SCMD_ATX, 50)}, stop_word(),
                 {short_fmt(0, SCMD_ATX, 51), long_fmt(0, LCMD_STOP, 0)},
                 48'h0, 48'h0, 1, 51, 0, 5);
        add_test("u1a_taken",
                 {short_fmt(0, SCMD_XTA, 40), long_fmt(0, LCMD_U1A, 3)},
                 {short_fmt(0, SCMD_ATX, 50), long_fmt(0, LCMD_STOP, 0)}, stop_word(),
                 {short_fmt(0, SCMD_ATX, 51), long_fmt(0, LCMD_STOP, 0)},
                 48'hdead_beef_0001, 48'hdead_beef_0001, 1, 51, 0, 3);
        add_test("uj_to_stop",
                 {long_fmt(0, LCMD_UJ, 2), short_fmt(0, SCMD_ATX, 50)},
                 {short_fmt(0, SCMD_ATX, 51), long_fmt(0, LCMD_STOP, 0)},
                 stop_word(), stop_word(),
                 48'h1111_2222_3333, 48'h1111_2222_3333, 0, 0, 0, 2);
        add_test("cached_word",                 // M1 = 3, then M1 = 2 + M1
                 {long_fmt(1, LCMD_VTM, 3), long_fmt(1, LCMD_UTM, 2)},
                 {short_fmt(1, SCMD_XTA, 35), short_fmt(1, SCMD_ATX, 50)},
                 stop_word(), stop_word(),
                 48'h7654_3210_fedc, 48'h7654_3210_fedc, 1, 55, 0, 4);

        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
            run_test(t[2:0]);

        $display("%0d of %0d tests passed, %0d failed", passed, NUM_TESTS, failed);
        if (failed == 0 && !timed_out)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/mesm_pkg.sv
logic/fetch_unit.sv
logic/exec_sequencer.sv
logic/address_unit.sv
logic/operand_unit.sv
logic/bus_arbiter.sv
logic/mesm_core.sv
tb/axi_mem_model.sv
tb/tb_mesm_core.sv
